// File: include/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Cache geometry
`define ICACHE_WAYS        4
`define ICACHE_SETS        128

// Address split is tag | index | offset
`define ICACHE_TAG_W       20
`define ICACHE_INDEX_W     7
`define ICACHE_OFFSET_W    5

`define ICACHE_WORD_W      32
`define ICACHE_LINE_WORDS  8
`define ICACHE_ADDR_W      32

`endif

// File: src/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_W-1:0]              tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]            index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0]           offset_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0]       way_t;
    typedef logic [`ICACHE_WAYS-1:0]               way_vec_t;
    typedef logic [`ICACHE_WORD_W-1:0]             word_t;
    // Word 0 in the low bits
    typedef word_t [`ICACHE_LINE_WORDS-1:0]        line_t;
    typedef logic [$clog2(`ICACHE_LINE_WORDS):0]   rnum_t;
    typedef logic [`ICACHE_ADDR_W-1:0]             addr_t;
    typedef tag_t [`ICACHE_WAYS-1:0]               way_tags_t;
    typedef line_t [`ICACHE_WAYS-1:0]              way_lines_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } req_t;

    typedef struct packed {
        logic   en;
        way_t   way;
        index_t index;
        tag_t   tag;
        line_t  data;
    } refill_t;

    typedef enum logic [1:0] {IDLE, LOOKUP, REPLACE, REFILL} ctrl_state_e;

endpackage

// File: src/icache_way_ram.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_way_ram
    import icache_pkg::*;
#(
    parameter way_t WAY_ID = '0
) (
    input  logic    clk,
    input  logic    resetn,
    input  logic    rd_en,
    input  index_t  rd_index,
    input  refill_t refill,
    output tag_t    tag_out,
    output line_t   line_out,
    output logic    valid_out
);

    tag_t                    tag_mem  [`ICACHE_SETS];
    line_t                   line_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_bits;
    logic                    wr_en;

    assign wr_en = refill.en && (refill.way == WAY_ID);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[refill.index]  <= refill.tag;
            line_mem[refill.index] <= refill.data;
        end
        if (rd_en) begin
            tag_out  <= tag_mem[rd_index];
            line_out <= line_mem[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            valid_out  <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_bits[refill.index] <= 1'b1;
            end
            // Reads and refills never target the same cycle
            if (rd_en) begin
                valid_out <= valid_bits[rd_index];
            end
        end
    end

endmodule

// File: src/icache_lookup.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  way_tags_t  way_tags,
    input  way_vec_t   way_valid,
    input  way_lines_t way_lines,
    input  tag_t       req_tag,
    output way_vec_t   way_hit,
    output logic       hit,
    output line_t      hit_line
);

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = way_valid[w] && (way_tags[w] == req_tag);
            // AND-OR select that relies on at most one hit
            hit_line = hit_line | ({$bits(line_t){way_hit[w]}} & way_lines[w]);
        end
    end

    assign hit = |way_hit;

    // A refill only ever targets a missing tag, so no tag lives in two ways
    always_comb begin
        if (!$isunknown(way_hit)) begin
            a_one_hit: assert final ($onehot0(way_hit))
                else $error("tag %h hit in more than one way: %b", req_tag, way_hit);
        end
    end

endmodule

// File: src/icache_plru.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_plru
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  index_t   index,
    input  logic     hit_upd,
    input  logic     victim_upd,
    input  way_vec_t way_hit,
    output way_t     victim
);

    way_vec_t [`ICACHE_SETS-1:0] mru;
    way_vec_t                    cur_bits;
    way_vec_t                    touch;
    way_vec_t                    next_bits;

    assign cur_bits = mru[index];

    // Lowest way not recently used
    always_comb begin
        victim = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!cur_bits[w]) begin
                victim = way_t'(w);
            end
        end
    end

    always_comb begin
        touch = '0;
        if (hit_upd) begin
            touch = way_hit;
        end else if (victim_upd) begin
            touch[victim] = 1'b1;
        end
    end

    // All bits set would leave no victim, so restart from the touched way
    always_comb begin
        next_bits = cur_bits | touch;
        if (&next_bits) begin
            next_bits = touch;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mru <= '0;
        end else if (hit_upd || victim_upd) begin
            mru[index] <= next_bits;
        end
    end

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    valid,
    input  tag_t    tag,
    input  index_t  index,
    input  offset_t offset,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  line_t   ret_data,
    input  logic    hit,
    input  line_t   hit_line,
    input  way_t    victim,
    output logic    addr_ok,
    output logic    data_ok,
    output line_t   rdata,
    output rnum_t   rnum,
    output logic    rd_req,
    output addr_t   rd_addr,
    output logic    rd_en,
    output index_t  rd_index,
    output tag_t    req_tag,
    output index_t  req_index,
    output logic    hit_upd,
    output logic    victim_upd,
    output refill_t refill
);

    localparam int WORD_LSB = $clog2(`ICACHE_WORD_W / 8);

    ctrl_state_e state;
    ctrl_state_e next_state;
    req_t        rb;
    way_t        rp_way;
    logic        take;

    assign addr_ok = valid && (state == IDLE || (state == LOOKUP && hit));
    assign take    = valid && addr_ok;

    // Way RAMs are read as the request is taken
    assign rd_en    = take;
    assign rd_index = index;

    always_ff @(posedge clk) begin
        if (take) begin
            rb <= '{tag: tag, index: index, offset: offset};
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP && !hit) begin
            rp_way <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (take) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!hit) begin
                    next_state = REPLACE;
                end else if (!take) begin
                    next_state = IDLE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    assign req_tag    = rb.tag;
    assign req_index  = rb.index;
    assign hit_upd    = (state == LOOKUP) && hit;
    assign victim_upd = (state == LOOKUP) && !hit;

    assign data_ok = ((state == LOOKUP) && hit) || ((state == REFILL) && ret_valid);
    // Returned line goes to the CPU as it is written
    assign rdata   = (state == REFILL) ? ret_data : hit_line;
    assign rnum    = rnum_t'(`ICACHE_LINE_WORDS)
                   - rnum_t'(rb.offset[`ICACHE_OFFSET_W-1:WORD_LSB]);

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {rb.tag, rb.index, offset_t'(0)};

    assign refill = '{
        en:    (state == REFILL) && ret_valid,
        way:   rp_way,
        index: rb.index,
        tag:   rb.tag,
        data:  ret_data
    };

    // A returned line outside REFILL would be lost
    a_ret_in_refill: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> state == REFILL)
        else $error("ret_valid arrived with no line read outstanding");

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    valid,
    input  tag_t    tag,
    input  index_t  index,
    input  offset_t offset,
    output logic    addr_ok,
    output logic    data_ok,
    output line_t   rdata,
    output rnum_t   rnum,
    output logic    rd_req,
    output addr_t   rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  line_t   ret_data
);

    logic       rd_en;
    index_t     rd_index;
    refill_t    refill;
    way_tags_t  way_tags;
    way_lines_t way_lines;
    way_vec_t   way_valid;
    way_vec_t   way_hit;
    logic       hit;
    line_t      hit_line;
    tag_t       req_tag;
    index_t     req_index;
    logic       hit_upd;
    logic       victim_upd;
    way_t       victim;

    icache_ctrl i_icache_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .tag        (tag),
        .index      (index),
        .offset     (offset),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .hit        (hit),
        .hit_line   (hit_line),
        .victim     (victim),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rnum       (rnum),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .hit_upd    (hit_upd),
        .victim_upd (victim_upd),
        .refill     (refill)
    );

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_way_ram #(
            .WAY_ID (way_t'(w))
        ) i_icache_way_ram (
            .clk       (clk),
            .resetn    (resetn),
            .rd_en     (rd_en),
            .rd_index  (rd_index),
            .refill    (refill),
            .tag_out   (way_tags[w]),
            .line_out  (way_lines[w]),
            .valid_out (way_valid[w])
        );
    end

    icache_lookup i_icache_lookup (
        .way_tags  (way_tags),
        .way_valid (way_valid),
        .way_lines (way_lines),
        .req_tag   (req_tag),
        .way_hit   (way_hit),
        .hit       (hit),
        .hit_line  (hit_line)
    );

    icache_plru i_icache_plru (
        .clk        (clk),
        .resetn     (resetn),
        .index      (req_index),
        .hit_upd    (hit_upd),
        .victim_upd (victim_upd),
        .way_hit    (way_hit),
        .victim     (victim)
    );

endmodule

// File: dv/icache_tb.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam logic [31:0] SEED = 32'h5b23383b;
    localparam int WD_CYCLES_PER_REQ = 200;
    localparam int RDY_DELAY_MAX = 3;
    localparam int RET_DELAY_MIN = 1;
    localparam int RET_DELAY_MAX = 5;

    logic    clk = 1'b0;
    logic    resetn;
    logic    valid;
    tag_t    tag;
    index_t  index;
    offset_t offset;
    logic    addr_ok;
    logic    data_ok;
    line_t   rdata;
    rnum_t   rnum;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    line_t   ret_data;

    int    cyc = 0;
    int    errors = 0;
    int    reqs_issued = 0;
    int    mem_reads = 0;
    int    last_accept = 0;
    int    rdy_delay = -1;
    addr_t last_rd_addr = '0;

    // Responses seen on data_ok in arrival order
    line_t resp_data [$];
    rnum_t resp_rnum [$];
    int    resp_cyc [$];

    // Reference model of tags and MRU bits per set
    tag_t     m_tag [`ICACHE_SETS][`ICACHE_WAYS];
    way_vec_t m_valid [`ICACHE_SETS];
    way_vec_t m_mru [`ICACHE_SETS];

    icache_top i_icache_top (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rnum      (rnum),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_equal(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic addr_t mk_addr(input tag_t t, input index_t s, input offset_t o);
        return {t, s, o};
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return {a[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], offset_t'(0)};
    endfunction

    // Word k of a line is its address XOR k * 01010101
    function automatic line_t line_pattern(input addr_t line_addr);
        line_t l;
        for (int k = 0; k < `ICACHE_LINE_WORDS; k++) begin
            l[k] = line_addr ^ (word_t'(k) * 32'h01010101);
        end
        return l;
    endfunction

    // Returns the predicted hit and updates tags and MRU bits
    function automatic bit model_access(input addr_t a);
        tag_t   t;
        index_t s;
        int     way;
        bit     is_hit;
        t = a[31:12];
        s = a[11:5];
        way = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                way = w;
            end
        end
        is_hit = (way >= 0);
        if (!is_hit) begin
            way = 0;
            for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
                if (!m_mru[s][w]) begin
                    way = w;
                end
            end
            m_tag[s][way] = t;
            m_valid[s][way] = 1'b1;
        end
        m_mru[s][way] = 1'b1;
        if (&m_mru[s]) begin
            m_mru[s] = way_vec_t'(1) << way;
        end
        return is_hit;
    endfunction

    // Memory side accepts a line read and returns the line later
    initial begin : mem_responder
        addr_t a;
        int    delay;
        int    lat;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_data = '0;
        forever begin
            @(negedge clk);
            if (resetn && rd_req) begin
                a = rd_addr;
                last_rd_addr = a;
                mem_reads++;
                delay = (rdy_delay >= 0) ? rdy_delay : $urandom_range(RDY_DELAY_MAX, 0);
                repeat (delay) begin
                    @(negedge clk);
                    check_equal("rd_req", rd_req, 1'b1);
                    check_equal("rd_addr", rd_addr, a);
                end
                @(posedge clk);
                #2 rd_rdy = 1'b1;
                @(posedge clk);
                #2 rd_rdy = 1'b0;
                lat = $urandom_range(RET_DELAY_MAX, RET_DELAY_MIN);
                repeat (lat - 1) begin
                    @(posedge clk);
                    #2;
                end
                ret_valid = 1'b1;
                ret_data = line_pattern(a);
                @(posedge clk);
                #2 ret_valid = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (resetn && data_ok) begin
            resp_data.push_back(rdata);
            resp_rnum.push_back(rnum);
            resp_cyc.push_back(cyc);
        end
        if (resetn && ret_valid) begin
            check_equal("data_ok", data_ok, 1'b1);
            check_equal("rdata", rdata, ret_data);
        end
    end

    // Leaves valid high and returns 2 ns after the accepting edge
    task automatic send_request(input addr_t a);
        valid = 1'b1;
        tag = a[31:12];
        index = a[11:5];
        offset = a[4:0];
        reqs_issued++;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        last_accept = cyc;
        @(posedge clk);
        #2;
    endtask

    task automatic check_response(input addr_t a, input bit exp_hit, input int reads0,
                                  input int acc);
        line_t got;
        rnum_t n;
        int    rc;
        while (resp_data.size() == 0) begin
            @(posedge clk);
        end
        got = resp_data.pop_front();
        n = resp_rnum.pop_front();
        rc = resp_cyc.pop_front();
        check_equal("rdata", got, line_pattern(line_of(a)));
        check_equal("rnum", n, `ICACHE_LINE_WORDS - a[4:2]);
        if (exp_hit) begin
            check_equal("hit latency", rc - acc, 1);
            check_equal("line reads", mem_reads - reads0, 0);
        end else begin
            check_equal("line reads", mem_reads - reads0, 1);
            check_equal("rd_addr", last_rd_addr, line_of(a));
        end
    endtask

    task automatic access(input addr_t a);
        bit exp_hit;
        int reads0;
        int acc;
        exp_hit = model_access(a);
        reads0 = mem_reads;
        send_request(a);
        acc = last_accept;
        valid = 1'b0;
        check_response(a, exp_hit, reads0, acc);
        @(posedge clk);
        #2;
    endtask

    task automatic cold_miss();
        access(mk_addr(20'h12345, 7'd3, 5'd8));
        access(mk_addr(20'h0F00D, 7'd77, 5'd28));
    endtask

    task automatic hit_after_fill();
        access(mk_addr(20'h12345, 7'd3, 5'd0));
        access(mk_addr(20'h0F00D, 7'd77, 5'd20));
    endtask

    task automatic pipelined_hits();
        addr_t base [3];
        addr_t a [6];
        int    acc [6];
        bit    exp [6];
        int    reads0;
        base[0] = mk_addr(20'h0BEEF, 7'd10, 5'd0);
        base[1] = mk_addr(20'h0CAFE, 7'd11, 5'd0);
        base[2] = mk_addr(20'h0D00D, 7'd12, 5'd0);
        for (int i = 0; i < 3; i++) begin
            access(base[i]);
        end
        for (int i = 0; i < 6; i++) begin
            a[i] = base[i % 3] | addr_t'($urandom_range(31, 0));
            exp[i] = model_access(a[i]);
        end
        reads0 = mem_reads;
        for (int i = 0; i < 6; i++) begin
            send_request(a[i]);
            acc[i] = last_accept;
            if (i > 0) begin
                check_equal("accept cycle", acc[i], acc[i-1] + 1);
            end
        end
        valid = 1'b0;
        for (int i = 0; i < 6; i++) begin
            check_response(a[i], exp[i], reads0, acc[i]);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic plru_eviction();
        tag_t t [5];
        for (int i = 0; i < 5; i++) begin
            t[i] = tag_t'(20'hA0000 + i);
        end
        for (int i = 0; i < 4; i++) begin
            access(mk_addr(t[i], 7'd40, 5'd0));
        end
        // Touch ways 0 and 2 so the fifth tag lands elsewhere
        access(mk_addr(t[0], 7'd40, 5'd4));
        access(mk_addr(t[2], 7'd40, 5'd8));
        access(mk_addr(t[4], 7'd40, 5'd0));
        access(mk_addr(t[0], 7'd40, 5'd12));
        access(mk_addr(t[2], 7'd40, 5'd16));
        access(mk_addr(t[3], 7'd40, 5'd24));
        access(mk_addr(t[4], 7'd40, 5'd28));
        access(mk_addr(t[1], 7'd40, 5'd0));
    endtask

    task automatic backpressure();
        addr_t a;
        addr_t b;
        bit    exp_a;
        int    reads0;
        int    acc;
        a = mk_addr(20'h5A5A5, 7'd9, 5'd12);
        b = mk_addr(20'h12345, 7'd3, 5'd4);
        rdy_delay = RDY_DELAY_MAX;
        exp_a = model_access(a);
        reads0 = mem_reads;
        send_request(a);
        acc = last_accept;
        // Next request waits on the bus during the whole refill
        tag = b[31:12];
        index = b[11:5];
        offset = b[4:0];
        do begin
            @(negedge clk);
            check_equal("addr_ok", addr_ok, 1'b0);
        end while (!data_ok);
        @(posedge clk);
        #2;
        check_response(a, exp_a, reads0, acc);
        rdy_delay = -1;
        access(b);
    endtask

    initial begin : watchdog
        @(posedge resetn);
        while (cyc < WD_CYCLES_PER_REQ * (reqs_issued + 1)) begin
            @(posedge clk);
        end
        $display("Timeout: no progress after %0d cycles with %0d requests issued",
                 cyc, reqs_issued);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        resetn = 1'b0;
        valid = 1'b0;
        tag = '0;
        index = '0;
        offset = '0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            m_valid[s] = '0;
            m_mru[s] = '0;
        end
        repeat (4) @(posedge clk);
        #2 resetn = 1'b1;
        cold_miss();
        hit_after_fill();
        pipelined_hits();
        plru_eviction();
        backpressure();
        repeat (4) @(posedge clk);
        $display("Run complete: %0d requests, %0d errors", reqs_issued, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
src/icache_pkg.sv
src/icache_way_ram.sv
src/icache_lookup.sv
src/icache_plru.sv
src/icache_ctrl.sv
src/icache_top.sv
dv/icache_tb.sv

// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - include

sources:
  - src/icache_pkg.sv
  - src/icache_way_ram.sv
  - src/icache_lookup.sv
  - src/icache_plru.sv
  - src/icache_ctrl.sv
  - src/icache_top.sv
  - target: test
    files:
      - dv/icache_tb.sv
